// ==== filelist.f ====
+incdir+source
+incdir+verif
source/sa_types_pkg.sv
source/sa_ctrl_pkg.sv
source/accum_adder.sv
source/pe.sv
source/input_skew.sv
source/systolic_array.sv
verif/tb_systolic_array.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_systolic_array -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_systolic_array)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The verdict comes from the testbench output only
if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== source/accum_adder.sv ====
`timescale 1ns/1ps
`include "sa_consts.svh"

module accum_adder (
    input  sa_ctrl_pkg::adder_mode_e i_mode,
    input  sa_types_pkg::product_t   i_product,
    input  sa_types_pkg::acc_t       i_acc,
    output sa_types_pkg::acc_t       o_sum
);
    import sa_types_pkg::*;
    import sa_ctrl_pkg::*;

    localparam int LOW_W  = `SA_IMPRECISE_PART;
    localparam int HIGH_W = `SA_ACC_W - LOW_W;

    acc_t              product_ext;
    acc_t              exact_sum;
    logic [LOW_W-1:0]  low_or;
    logic              low_carry;
    logic [HIGH_W-1:0] high_sum;
    acc_t              loa_sum;

    // Signed cast widens with the product's sign bit
    assign product_ext = acc_t'(i_product);

    ////////////////////////////////////////////////////////////////////////
    // Accurate core
    ////////////////////////////////////////////////////////////////////////
    assign exact_sum = product_ext + i_acc;     // Wraps at the accumulator width

    ////////////////////////////////////////////////////////////////////////
    // Lower-part-OR core
    ////////////////////////////////////////////////////////////////////////

    // No carry chain through the low part
    assign low_or = product_ext[LOW_W-1:0] | i_acc[LOW_W-1:0];

    // Carry guess from the top bit of the low part
    assign low_carry = product_ext[LOW_W-1] & i_acc[LOW_W-1];

    assign high_sum = product_ext[`SA_ACC_W-1:LOW_W]
                    + i_acc[`SA_ACC_W-1:LOW_W]
                    + HIGH_W'(low_carry);

    assign loa_sum = {high_sum, low_or};

    // Mode select
    always_comb begin
        case (i_mode)
            ADD_LOA: o_sum = loa_sum;
            default: o_sum = exact_sum;
        endcase
    end

endmodule

// ==== source/input_skew.sv ====
`timescale 1ns/1ps
`include "sa_consts.svh"

module input_skew (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sa_types_pkg::edge_feed_t i_feed,
    output sa_types_pkg::edge_feed_t o_feed
);
    import sa_types_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Triangular delay lines, lane n is n cycles deep
    ////////////////////////////////////////////////////////////////////////

    for (genvar lane = 0; lane < `SA_DIM; lane++) begin : g_lane
        if (lane == 0) begin : g_direct
            // Corner PE sees its operands straight away
            assign o_feed.pixels[lane]  = i_feed.pixels[lane];
            assign o_feed.weights[lane] = i_feed.weights[lane];
        end else begin : g_delay
            pixel_t  pix_sr [lane];     // Stage 0 is nearest the input
            weight_t wgt_sr [lane];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    pix_sr <= '{default: '0};
                    wgt_sr <= '{default: '0};
                end else begin
                    pix_sr[0] <= i_feed.pixels[lane];
                    wgt_sr[0] <= i_feed.weights[lane];
                    for (int s = 1; s < lane; s++) begin
                        pix_sr[s] <= pix_sr[s-1];
                        wgt_sr[s] <= wgt_sr[s-1];
                    end
                end
            end

            // Tail of each line
            assign o_feed.pixels[lane]  = pix_sr[lane-1];
            assign o_feed.weights[lane] = wgt_sr[lane-1];
        end
    end

endmodule

// ==== source/pe.sv ====
`timescale 1ns/1ps

module pe (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_clear,       // Zero the accumulator
    input  sa_ctrl_pkg::adder_mode_e i_adder_mode,
    input  sa_types_pkg::pixel_t     i_pixel,
    input  sa_types_pkg::weight_t    i_weight,
    output sa_types_pkg::pixel_t     o_pixel,       // To the PE on the right
    output sa_types_pkg::weight_t    o_weight,      // To the PE below
    output sa_types_pkg::acc_t       o_acc
);
    import sa_types_pkg::*;

    product_t product;
    acc_t     acc_q;
    acc_t     acc_next;

    ////////////////////////////////////////////////////////////////////////
    // Operand pass-through
    ////////////////////////////////////////////////////////////////////////

    // One cycle per hop keeps the wavefront aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pixel  <= '0;
            o_weight <= '0;
        end else begin
            o_pixel  <= i_pixel;
            o_weight <= i_weight;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Multiply-accumulate
    ////////////////////////////////////////////////////////////////////////

    // Both operands signed, so the product is two's complement
    assign product = i_pixel * i_weight;

    accum_adder u_accum_adder (
        .i_mode    (i_adder_mode),
        .i_product (product),
        .i_acc     (acc_q),
        .o_sum     (acc_next)
    );

    // Clear beats the new product on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (i_clear) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_next;
        end
    end

    assign o_acc = acc_q;

endmodule

// ==== source/sa_consts.svh ====
`ifndef SA_CONSTS_SVH
`define SA_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Data path widths
////////////////////////////////////////////////////////////////////////////
`define SA_DW 8                 // Pixel width
`define SA_WW 8                 // Weight width

////////////////////////////////////////////////////////////////////////////
// Array geometry and accumulation
////////////////////////////////////////////////////////////////////////////
`define SA_DIM 3                // Rows and columns of the PE grid
`define SA_MAX_DEPTH 16         // Most products folded into one tile

// Room for a full tile of full-scale products
`define SA_ACC_W (`SA_DW + `SA_WW + $clog2(`SA_MAX_DEPTH))

`define SA_IMPRECISE_PART 4     // Low bits handled by the OR part of the LOA

`endif

// ==== source/sa_ctrl_pkg.sv ====
package sa_ctrl_pkg;

    // Accumulation core picked at run time
    typedef enum logic {
        ADD_ACCURATE = 1'b0,    // Exact carry-propagate sum
        ADD_LOA      = 1'b1     // Lower-part-OR approximate sum
    } adder_mode_e;

endpackage

// ==== source/sa_types_pkg.sv ====
package sa_types_pkg;

`include "sa_consts.svh"

    // Operands as they enter the array
    typedef logic signed [`SA_DW-1:0] pixel_t;
    typedef logic signed [`SA_WW-1:0] weight_t;

    // Full-precision multiplier output
    typedef logic signed [`SA_DW+`SA_WW-1:0] product_t;

    typedef logic signed [`SA_ACC_W-1:0] acc_t;     // One PE accumulator

    // Left edge carries one pixel per row, top edge one weight per column
    typedef struct packed {
        pixel_t  [`SA_DIM-1:0] pixels;
        weight_t [`SA_DIM-1:0] weights;
    } edge_feed_t;

    // Whole result grid, first index is the row
    typedef acc_t [`SA_DIM-1:0][`SA_DIM-1:0] acc_grid_t;

endpackage

// ==== source/systolic_array.sv ====
`timescale 1ns/1ps
`include "sa_consts.svh"

module systolic_array (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_clear,       // One-cycle tile start pulse
    input  sa_ctrl_pkg::adder_mode_e i_adder_mode,  // Held for a whole tile
    input  sa_types_pkg::edge_feed_t i_feed,
    output sa_types_pkg::acc_grid_t  o_acc
);
    import sa_types_pkg::*;

    edge_feed_t skewed;

    // Links between neighbours, indexed by the driving PE
    pixel_t  pix_link [`SA_DIM][`SA_DIM-1];    // Rightward hops
    weight_t wgt_link [`SA_DIM-1][`SA_DIM];    // Downward hops

    input_skew u_input_skew (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_feed (i_feed),
        .o_feed (skewed)
    );

    ////////////////////////////////////////////////////////////////////////
    // PE grid
    ////////////////////////////////////////////////////////////////////////

    for (genvar r = 0; r < `SA_DIM; r++) begin : g_row
        for (genvar c = 0; c < `SA_DIM; c++) begin : g_col
            pixel_t  pix_in;
            weight_t wgt_in;

            // Left column takes the skewed pixels
            if (c == 0) begin : g_pix_edge
                assign pix_in = skewed.pixels[r];
            end else begin : g_pix_link
                assign pix_in = pix_link[r][c-1];
            end

            // Top row takes the skewed weights
            if (r == 0) begin : g_wgt_edge
                assign wgt_in = skewed.weights[c];
            end else begin : g_wgt_link
                assign wgt_in = wgt_link[r-1][c];
            end

            // Right column and bottom row drop their outgoing operands
            if (c < `SA_DIM-1 && r < `SA_DIM-1) begin : g_inner
                pe u_pe (
                    .clk, .rst_n, .i_clear, .i_adder_mode,
                    .i_pixel(pix_in), .i_weight(wgt_in),
                    .o_pixel(pix_link[r][c]), .o_weight(wgt_link[r][c]),
                    .o_acc(o_acc[r][c])
                );
            end else if (c < `SA_DIM-1) begin : g_bottom
                pe u_pe (
                    .clk, .rst_n, .i_clear, .i_adder_mode,
                    .i_pixel(pix_in), .i_weight(wgt_in),
                    .o_pixel(pix_link[r][c]), .o_weight(),
                    .o_acc(o_acc[r][c])
                );
            end else if (r < `SA_DIM-1) begin : g_right
                pe u_pe (
                    .clk, .rst_n, .i_clear, .i_adder_mode,
                    .i_pixel(pix_in), .i_weight(wgt_in),
                    .o_pixel(), .o_weight(wgt_link[r][c]),
                    .o_acc(o_acc[r][c])
                );
            end else begin : g_corner
                pe u_pe (
                    .clk, .rst_n, .i_clear, .i_adder_mode,
                    .i_pixel(pix_in), .i_weight(wgt_in),
                    .o_pixel(), .o_weight(),
                    .o_acc(o_acc[r][c])
                );
            end
        end
    end

endmodule

// ==== verif/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Stimulus generator
////////////////////////////////////////////////////////////////////////////

    // 13/17/5 xorshift, never reaches zero from a nonzero seed
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

////////////////////////////////////////////////////////////////////////////
// Accumulation rule and tile results
////////////////////////////////////////////////////////////////////////////

    // One accumulation step, worked out on plain integers
    function automatic acc_t model_add(adder_mode_e mode, product_t p, acc_t a);
        longint pv;
        longint av;
        longint lo_mask;
        longint low;
        longint carry;
        longint high;
        pv = longint'(p);
        av = longint'(a);
        if (mode == ADD_ACCURATE) begin
            return acc_t'(pv + av);     // Truncation gives the modulo
        end
        lo_mask = (64'sd1 <<< `SA_IMPRECISE_PART) - 64'sd1;
        low     = (pv & lo_mask) | (av & lo_mask);
        carry   = (pv >> (`SA_IMPRECISE_PART - 1)) & (av >> (`SA_IMPRECISE_PART - 1)) & 64'sd1;
        high    = (pv >>> `SA_IMPRECISE_PART) + (av >>> `SA_IMPRECISE_PART) + carry;
        return acc_t'((high <<< `SA_IMPRECISE_PART) | low);
    endfunction

    // Plain dot product of pixel row r and weight column c
    function automatic acc_t exact_dot(int r, int c);
        longint sum;
        sum = 64'sd0;
        for (int k = 0; k < tile_len; k++) begin
            sum = sum + longint'(tile_pix[k][r]) * longint'(tile_wgt[k][c]);
        end
        return acc_t'(sum);
    endfunction

    // Fold of the first n_terms products in arrival order
    function automatic acc_t fold_expected(int r, int c, int n_terms, adder_mode_e mode);
        acc_t     acc;
        product_t prod;
        acc = '0;
        for (int k = 0; k < n_terms; k++) begin
            prod = product_t'(longint'(tile_pix[k][r]) * longint'(tile_wgt[k][c]));
            acc  = model_add(mode, prod, acc);
        end
        return acc;
    endfunction

    // Pairs already folded into PE(r,c), e edges after pair 0 was driven
    function automatic int terms_done(int e, int r, int c);
        int n;
        n = e - r - c;
        if (n < 0) n = 0;
        if (n > tile_len) n = tile_len;
        return n;
    endfunction

`endif

// ==== verif/tb_systolic_array.sv ====
`timescale 1ns/1ps
`include "sa_consts.svh"

module tb_systolic_array;
    import sa_types_pkg::*;
    import sa_ctrl_pkg::*;

    localparam int NUM_TILES   = 10;
    localparam int FLUSH       = 2 * (`SA_DIM - 1) + 1;    // Edges to drain the wavefront
    localparam int WATCHDOG_NS =
        (NUM_TILES * (`SA_MAX_DEPTH + 2 * `SA_DIM + 2) + 20) * 20 * 2;
    localparam acc_t FULL_SCALE_SUM = acc_t'(262144);       // 16 x (-128 x -128)
    localparam acc_t ALT_SIGN_SUM   = acc_t'(1024);         // 8 x (16384 - 16256)

    logic        clk;
    logic        rst_n;
    logic        i_clear;
    adder_mode_e i_adder_mode;
    edge_feed_t  i_feed;
    acc_grid_t   o_acc;

    // Operands of the tile in flight indexed by pair first
    pixel_t      tile_pix [`SA_MAX_DEPTH][`SA_DIM];
    weight_t     tile_wgt [`SA_MAX_DEPTH][`SA_DIM];
    int          tile_len;
    adder_mode_e tile_mode;

    logic [31:0] rng_state;
    int          error_count;
    int          check_count;
    bit          loa_differs;      // Set once an LOA tile leaves the exact result

`include "tb_ref_model.svh"

    systolic_array dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_clear      (i_clear),
        .i_adder_mode (i_adder_mode),
        .i_feed       (i_feed),
        .o_acc        (o_acc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Whole grid reads zero one edge after a clear is sampled
    clear_zeroes_grid: assert property (@(posedge clk) disable iff (!rst_n)
        i_clear |=> (o_acc == '0))
    else begin
        error_count++;
        $display("** Error at %0t ns: dut.o_acc after clear expected 0, got %h", $time, o_acc);
    end

////////////////////////////////////////////////////////////////////////////
// Checks and drivers
////////////////////////////////////////////////////////////////////////////

    task automatic check_acc(int r, int c, acc_t expected, string what);
        check_count++;
        assert (o_acc[r][c] == expected) else begin
            error_count++;
            $display("** Error at %0t ns: dut.o_acc[%0d][%0d] (%s) expected %0d, got %0d",
                     $time, r, c, what, expected, o_acc[r][c]);
        end
    endtask

    // Negative k feeds zero operands
    task automatic drive(logic clear, int k);
        edge_feed_t feed;
        feed = '0;
        if (k >= 0) begin
            for (int i = 0; i < `SA_DIM; i++) begin
                feed.pixels[i]  = tile_pix[k][i];
                feed.weights[i] = tile_wgt[k][i];
            end
        end
        @(posedge clk);
        i_clear      <= clear;
        i_adder_mode <= tile_mode;
        i_feed       <= feed;
    endtask

    task automatic fill_random(int len);
        rng_state = xorshift32(rng_state);
        tile_len  = (len > 0) ? len : int'(rng_state[3:0]) + 1;
        for (int k = 0; k < tile_len; k++) begin
            for (int i = 0; i < `SA_DIM; i++) begin
                rng_state      = xorshift32(rng_state);
                tile_pix[k][i] = pixel_t'(rng_state[7:0]);
                tile_wgt[k][i] = weight_t'(rng_state[15:8]);
            end
        end
    endtask

    // Clear, the pairs, then zeros until the corner PE is done
    task automatic run_tile();
        acc_t first_prod;
        first_prod = acc_t'(longint'(tile_pix[0][0]) * longint'(tile_wgt[0][0]));
        drive(1'b1, -1);
        for (int e = 0; e < tile_len + FLUSH; e++) begin
            drive(1'b0, (e < tile_len) ? e : -1);
            @(negedge clk);
            for (int r = 0; r < `SA_DIM; r++) begin
                for (int c = 0; c < `SA_DIM; c++) begin
                    check_acc(r, c, fold_expected(r, c, terms_done(e, r, c), tile_mode),
                              "running sum");
                end
            end
            if (e == 1) check_acc(0, 0, first_prod, "first product");
            if (e < FLUSH) check_acc(`SA_DIM - 1, `SA_DIM - 1, '0, "corner before wavefront");
        end
        for (int r = 0; r < `SA_DIM; r++) begin
            for (int c = 0; c < `SA_DIM; c++) begin
                if (tile_mode == ADD_ACCURATE) begin
                    check_acc(r, c, exact_dot(r, c), "signed matrix product");
                end else if (o_acc[r][c] != exact_dot(r, c)) begin
                    loa_differs = 1'b1;
                end
            end
        end
    endtask

    // Same operands on every lane with even and odd pairs free to differ
    task automatic run_directed(pixel_t p_even, pixel_t p_odd, weight_t w, acc_t expected,
                                string what);
        tile_mode = ADD_ACCURATE;
        tile_len  = `SA_MAX_DEPTH;
        for (int k = 0; k < tile_len; k++) begin
            for (int i = 0; i < `SA_DIM; i++) begin
                tile_pix[k][i] = (k % 2 == 0) ? p_even : p_odd;
                tile_wgt[k][i] = w;
            end
        end
        run_tile();
        for (int r = 0; r < `SA_DIM; r++) begin
            for (int c = 0; c < `SA_DIM; c++) begin
                check_acc(r, c, expected, what);
            end
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        i_clear      = 1'b0;
        i_adder_mode = ADD_ACCURATE;
        i_feed       = '0;
        tile_len     = 0;
        tile_mode    = ADD_ACCURATE;
        rng_state    = 32'h36af8eb2;
        error_count  = 0;
        check_count  = 0;
        loa_differs  = 1'b0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int r = 0; r < `SA_DIM; r++) begin
            for (int c = 0; c < `SA_DIM; c++) begin
                check_acc(r, c, '0, "after reset");
            end
        end

        // Extreme operands run back to back with the random tiles
        run_directed(pixel_t'(-128), pixel_t'(-128), weight_t'(-128), FULL_SCALE_SUM,
                     "full-scale sum");
        run_directed(pixel_t'(-128), pixel_t'(127), weight_t'(-128), ALT_SIGN_SUM,
                     "alternating signs");

        repeat (4) begin
            tile_mode = ADD_ACCURATE;
            fill_random(0);
            run_tile();
        end
        repeat (4) begin
            tile_mode = ADD_LOA;
            fill_random(`SA_MAX_DEPTH);     // Long tiles give the carry guess room to miss
            run_tile();
        end

        check_count++;
        assert (loa_differs) else begin
            error_count++;
            $display("No LOA tile gave a result different from the exact product");
        end

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
